// File: src/tile_render_pkg.sv
package tile_render_pkg;

  // Line, tile and map geometry
  localparam int LINE_WIDTH   = 64;
  localparam int TILE_SIZE    = 8;
  localparam int MAP_TILES    = 16;
  localparam int NUM_LAYERS   = 2;
  localparam int X_WIDTH      = 7;
  localparam int LINE_Y_WIDTH = 7;

  localparam int TILE_BITS  = $clog2(TILE_SIZE);
  localparam int MAP_BITS   = $clog2(MAP_TILES);
  localparam int LAYER_BITS = $clog2(NUM_LAYERS);
  localparam int BUF_X_BITS = $clog2(LINE_WIDTH);

  // Memory ports
  localparam int MAP_ADDR_WIDTH  = 9;
  localparam int MAP_DATA_WIDTH  = 8;
  localparam int VRAM_ADDR_WIDTH = 16;
  localparam int VRAM_DATA_WIDTH = 16;
  localparam int PAL_ADDR_WIDTH  = 10;
  localparam int PAL_DATA_WIDTH  = 24;
  localparam int RGB_WIDTH       = 18;

  localparam int TEXEL_WIDTH    = 8;
  localparam int PAL_BANK_WIDTH = PAL_ADDR_WIDTH - TEXEL_WIDTH;
  localparam int WORDS_PER_TILE = 32;
  localparam int PIPE_DEPTH     = 3;

  // Map entry layout when flipping is enabled
  localparam int FLIP_X_BIT      = 7;
  localparam int FLIP_Y_BIT      = 6;
  localparam int FLIP_XY_BIT     = 5;
  localparam int TILE_VALUE_BITS = 5;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DRAW,
    ST_DONE
  } render_state_t;

  typedef struct packed {
    logic                       enabled;
    logic                       enable_flip;
    logic                       enable_nop;
    logic                       enable_transp;
    logic [PAL_BANK_WIDTH-1:0]  pal_bank;
    logic [MAP_DATA_WIDTH-1:0]  nop_value;
    logic [TEXEL_WIDTH-1:0]     color_key;
    // In VRAM words
    logic [VRAM_ADDR_WIDTH-1:0] data_offset;
    logic [X_WIDTH-1:0]         offset_x;
    logic [LINE_Y_WIDTH-1:0]    offset_y;
  } layer_cfg_t;

  typedef struct packed {
    logic [X_WIDTH-1:0]               scroll_x;
    logic [LINE_Y_WIDTH-1:0]          scroll_y;
    layer_cfg_t [NUM_LAYERS-1:0]      layer;
  } render_cfg_t;

  typedef struct packed {
    logic                    valid;
    logic [LAYER_BITS-1:0]   layer;
    logic                    half;
    logic [X_WIDTH-1:0]      buf_x;
    logic [LINE_Y_WIDTH-1:0] line_y;
  } map_op_t;

  typedef struct packed {
    logic                  valid;
    logic [LAYER_BITS-1:0] layer;
    logic                  half;
    logic [X_WIDTH-1:0]    buf_x;
    logic [TILE_BITS-1:0]  tile_x;
    logic [TILE_BITS-1:0]  tile_y;
  } fetch_op_t;

  typedef struct packed {
    logic                  valid;
    logic [LAYER_BITS-1:0] layer;
    logic                  half;
    logic [X_WIDTH-1:0]    buf_x;
    logic                  byte_sel;
    logic                  skip;
  } texel_op_t;

  typedef struct packed {
    logic               valid;
    logic               half;
    logic [X_WIDTH-1:0] buf_x;
  } write_op_t;

endpackage

// File: src/render_sequencer.sv
`timescale 1ns/1ps

module render_sequencer
  import tile_render_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req,
  input  logic [LINE_Y_WIDTH-1:0] line_y,
  input  render_cfg_t             cfg,
  output logic                    ack,
  output map_op_t                 op
);

  render_state_t                    state;
  logic [LAYER_BITS-1:0]            layer;
  logic [X_WIDTH-1:0]               x;
  logic [$clog2(PIPE_DEPTH+1)-1:0]  drain_cnt;
  int                               search_from;
  logic                             next_found;
  logic [LAYER_BITS-1:0]            next_layer;
  logic                             last_x;

  // Lowest enabled layer at or above search_from, so disabled layers cost nothing
  always_comb begin
    search_from = (state == ST_IDLE) ? 0 : int'(layer) + 1;
    next_found  = 1'b0;
    next_layer  = '0;
    for (int i = NUM_LAYERS - 1; i >= 0; i--) begin
      if (cfg.layer[i].enabled && (i >= search_from)) begin
        next_found = 1'b1;
        next_layer = LAYER_BITS'(i);
      end
    end
  end

  assign last_x = (x == X_WIDTH'(LINE_WIDTH - 1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= ST_IDLE;
      layer     <= '0;
      x         <= '0;
      drain_cnt <= '0;
      ack       <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req) begin
            x         <= '0;
            drain_cnt <= '0;
            if (next_found) begin
              state <= ST_DRAW;
              layer <= next_layer;
            end else begin
              state <= ST_DONE;
            end
          end
        end
        ST_DRAW: begin
          if (last_x) begin
            x <= '0;
            if (next_found) begin
              layer <= next_layer;
            end else begin
              state <= ST_DONE;
            end
          end else begin
            x <= x + 1;
          end
        end
        ST_DONE: begin
          // Let the last pixels drain through the pipeline before answering
          if (!ack) begin
            if (drain_cnt == PIPE_DEPTH - 1) begin
              ack <= 1'b1;
            end else begin
              drain_cnt <= drain_cnt + 1;
            end
          end else if (!req) begin
            ack   <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_comb begin
    op.valid  = (state == ST_DRAW);
    op.layer  = layer;
    op.half   = line_y[0];
    op.buf_x  = x;
    op.line_y = line_y;
  end

  // Handshake: ack only comes up while the request is still held
  ack_needs_req_a: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req);

endmodule

// File: src/tile_map_stage.sv
`timescale 1ns/1ps

module tile_map_stage
  import tile_render_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  render_cfg_t               cfg,
  input  map_op_t                   op_in,
  output logic [MAP_ADDR_WIDTH-1:0] map_addr,
  output fetch_op_t                 op_out
);

  layer_cfg_t              lcfg;
  logic [X_WIDTH-1:0]      world_x;
  logic [LINE_Y_WIDTH-1:0] world_y;

  assign lcfg = cfg.layer[op_in.layer];

  // Truncation to 7 bits gives the wrap at the 128 pixel world edge
  assign world_x = op_in.buf_x + cfg.scroll_x - lcfg.offset_x;
  assign world_y = op_in.line_y + cfg.scroll_y - lcfg.offset_y;

  // Map address is layer, then map row, then map column
  assign map_addr = {op_in.layer,
                     world_y[LINE_Y_WIDTH-1 -: MAP_BITS],
                     world_x[X_WIDTH-1 -: MAP_BITS]};

  // Tile-local position travels with the op while the map read is in flight
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      op_out <= '0;
    end else begin
      op_out.valid  <= op_in.valid;
      op_out.layer  <= op_in.layer;
      op_out.half   <= op_in.half;
      op_out.buf_x  <= op_in.buf_x;
      op_out.tile_x <= world_x[TILE_BITS-1:0];
      op_out.tile_y <= world_y[TILE_BITS-1:0];
    end
  end

endmodule

// File: src/texel_fetch_stage.sv
`timescale 1ns/1ps

module texel_fetch_stage
  import tile_render_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  render_cfg_t                cfg,
  input  fetch_op_t                  op_in,
  input  logic [MAP_DATA_WIDTH-1:0]  map_data,
  output logic [VRAM_ADDR_WIDTH-1:0] vram_addr,
  output texel_op_t                  op_out
);

  layer_cfg_t                 lcfg;
  logic                       flip_x;
  logic                       flip_y;
  logic                       flip_xy;
  logic [MAP_DATA_WIDTH-1:0]  tile_value;
  logic [TILE_BITS-1:0]       tx;
  logic [TILE_BITS-1:0]       ty;
  logic [VRAM_ADDR_WIDTH-1:0] tile_word;
  logic [VRAM_ADDR_WIDTH-1:0] row_word;

  assign lcfg = cfg.layer[op_in.layer];

  // Flip bits only exist when the layer enables them
  assign flip_x     = lcfg.enable_flip & map_data[FLIP_X_BIT];
  assign flip_y     = lcfg.enable_flip & map_data[FLIP_Y_BIT];
  assign flip_xy    = lcfg.enable_flip & map_data[FLIP_XY_BIT];
  assign tile_value = lcfg.enable_flip ? MAP_DATA_WIDTH'(map_data[TILE_VALUE_BITS-1:0])
                                       : map_data;

  // Diagonal flip swaps the axes first
  always_comb begin
    if (flip_xy) begin
      tx = flip_y ? ~op_in.tile_y : op_in.tile_y;
      ty = flip_x ? ~op_in.tile_x : op_in.tile_x;
    end else begin
      tx = flip_x ? ~op_in.tile_x : op_in.tile_x;
      ty = flip_y ? ~op_in.tile_y : op_in.tile_y;
    end
  end

  // Two texels per word, so the row holds four words
  assign tile_word = VRAM_ADDR_WIDTH'(tile_value) * VRAM_ADDR_WIDTH'(WORDS_PER_TILE);
  assign row_word  = VRAM_ADDR_WIDTH'({ty, tx[TILE_BITS-1:1]});
  assign vram_addr = lcfg.data_offset + tile_word + row_word;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      op_out <= '0;
    end else begin
      op_out.valid    <= op_in.valid;
      op_out.layer    <= op_in.layer;
      op_out.half     <= op_in.half;
      op_out.buf_x    <= op_in.buf_x;
      op_out.byte_sel <= tx[0];
      op_out.skip     <= lcfg.enable_nop && (tile_value == lcfg.nop_value);
    end
  end

endmodule

// File: src/palette_stage.sv
`timescale 1ns/1ps

module palette_stage
  import tile_render_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  render_cfg_t                cfg,
  input  texel_op_t                  op_in,
  input  logic [VRAM_DATA_WIDTH-1:0] vram_data,
  output logic [PAL_ADDR_WIDTH-1:0]  pal_addr,
  output write_op_t                  op_out
);

  layer_cfg_t             lcfg;
  logic [TEXEL_WIDTH-1:0] texel;
  logic                   transparent;
  logic                   write_en;

  assign lcfg = cfg.layer[op_in.layer];

  // Odd texel lives in the high byte
  assign texel = op_in.byte_sel ? vram_data[VRAM_DATA_WIDTH-1 -: TEXEL_WIDTH]
                                : vram_data[TEXEL_WIDTH-1:0];

  assign transparent = lcfg.enable_transp && (texel == lcfg.color_key);

  // Bank picks one of four 256-colour palettes
  assign pal_addr = {lcfg.pal_bank, texel};

  // NOP tiles and keyed texels leave the lower layer in place
  assign write_en = op_in.valid && !op_in.skip && !transparent;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      op_out <= '0;
    end else begin
      op_out.valid <= write_en;
      op_out.half  <= op_in.half;
      op_out.buf_x <= op_in.buf_x;
    end
  end

endmodule

// File: src/line_buffer.sv
`timescale 1ns/1ps

module line_buffer
  import tile_render_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  write_op_t                 wr_op,
  input  logic [PAL_DATA_WIDTH-1:0] pal_data,
  input  logic                      scan_en,
  input  logic [BUF_X_BITS-1:0]     scan_x,
  input  logic                      scan_half,
  output logic [RGB_WIDTH-1:0]      rgb,
  output logic                      rgb_valid
);

  // Two halves, one being drawn while the other scans out
  logic [PAL_DATA_WIDTH-1:0] mem [2][LINE_WIDTH];
  logic [PAL_DATA_WIDTH-1:0] rd_data;
  logic                      scan_en_q;

  // Palette data arrives in the same cycle as the write op
  always_ff @(posedge clk) begin
    if (wr_op.valid) begin
      mem[wr_op.half][wr_op.buf_x[BUF_X_BITS-1:0]] <= pal_data;
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= mem[scan_half][scan_x];
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      scan_en_q <= 1'b0;
      rgb       <= '0;
      rgb_valid <= 1'b0;
    end else begin
      scan_en_q <= scan_en;
      rgb_valid <= scan_en_q;
      // blue, green, red, top six bits each
      if (scan_en_q) begin
        rgb <= {rd_data[23:18], rd_data[15:10], rd_data[7:2]};
      end else begin
        rgb <= '0;
      end
    end
  end

  // Sequencer x count must stay inside one line
  wr_in_line_a: assert property (@(posedge clk) disable iff (reset)
    wr_op.valid |-> (wr_op.buf_x < X_WIDTH'(LINE_WIDTH)));

endmodule

// File: src/tile_renderer.sv
`timescale 1ns/1ps

module tile_renderer
  import tile_render_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  render_cfg_t                cfg,
  input  logic                       req,
  input  logic [LINE_Y_WIDTH-1:0]    line_y,
  output logic                       ack,
  output logic [MAP_ADDR_WIDTH-1:0]  map_addr,
  input  logic [MAP_DATA_WIDTH-1:0]  map_data,
  output logic [VRAM_ADDR_WIDTH-1:0] vram_addr,
  input  logic [VRAM_DATA_WIDTH-1:0] vram_data,
  output logic [PAL_ADDR_WIDTH-1:0]  pal_addr,
  input  logic [PAL_DATA_WIDTH-1:0]  pal_data,
  input  logic                       scan_en,
  input  logic [BUF_X_BITS-1:0]      scan_x,
  input  logic                       scan_half,
  output logic [RGB_WIDTH-1:0]       rgb,
  output logic                       rgb_valid
);

  map_op_t   map_op;
  fetch_op_t fetch_op;
  texel_op_t texel_op;
  write_op_t write_op;

  render_sequencer seq_i (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .line_y (line_y),
    .cfg    (cfg),
    .ack    (ack),
    .op     (map_op)
  );

  // Each stage sees the memory data for the op it just registered
  tile_map_stage map_i (
    .clk      (clk),
    .reset    (reset),
    .cfg      (cfg),
    .op_in    (map_op),
    .map_addr (map_addr),
    .op_out   (fetch_op)
  );

  texel_fetch_stage fetch_i (
    .clk       (clk),
    .reset     (reset),
    .cfg       (cfg),
    .op_in     (fetch_op),
    .map_data  (map_data),
    .vram_addr (vram_addr),
    .op_out    (texel_op)
  );

  palette_stage pal_i (
    .clk       (clk),
    .reset     (reset),
    .cfg       (cfg),
    .op_in     (texel_op),
    .vram_data (vram_data),
    .pal_addr  (pal_addr),
    .op_out    (write_op)
  );

  line_buffer buf_i (
    .clk       (clk),
    .reset     (reset),
    .wr_op     (write_op),
    .pal_data  (pal_data),
    .scan_en   (scan_en),
    .scan_x    (scan_x),
    .scan_half (scan_half),
    .rgb       (rgb),
    .rgb_valid (rgb_valid)
  );

endmodule

// File: test/tb_video_mem.sv
`timescale 1ns/1ps

module tb_video_mem
  import tile_render_pkg::*;
(
  input  logic                       clk,
  input  logic [MAP_ADDR_WIDTH-1:0]  map_addr,
  output logic [MAP_DATA_WIDTH-1:0]  map_data,
  input  logic [VRAM_ADDR_WIDTH-1:0] vram_addr,
  output logic [VRAM_DATA_WIDTH-1:0] vram_data,
  input  logic [PAL_ADDR_WIDTH-1:0]  pal_addr,
  output logic [PAL_DATA_WIDTH-1:0]  pal_data
);

  logic [7:0] vram_fold;

  // Upper address bits only touch the two texel bits that RGB drops
  assign vram_fold = {6'h00, vram_addr[15:14] ^ vram_addr[13:12] ^ vram_addr[11:10] ^
                      vram_addr[9:8]};

  // All three memories answer one cycle after the address
  always_ff @(posedge clk) begin
    map_data  <= MAP_DATA_WIDTH'(int'(map_addr) * 37 + 11);
    // Even texel is the low address byte, odd texel its inverse
    vram_data <= {~vram_addr[7:0] ^ vram_fold, vram_addr[7:0]};
    // Blue carries the bank, green the inverted texel, red the texel
    pal_data  <= {pal_addr[9:8], 6'h00, ~pal_addr[7:0], pal_addr[7:0]};
  end

endmodule

// File: test/tile_renderer_tb.sv
`timescale 1ns/1ps

module tile_renderer_tb
  import tile_render_pkg::*;
;

  localparam int MAX_REC = 8;
  localparam int FIELDS  = 10;

  logic                       clk;
  logic                       reset;
  render_cfg_t                cfg;
  logic                       req;
  logic [LINE_Y_WIDTH-1:0]    line_y;
  logic                       ack;
  logic [MAP_ADDR_WIDTH-1:0]  map_addr;
  logic [MAP_DATA_WIDTH-1:0]  map_data;
  logic [VRAM_ADDR_WIDTH-1:0] vram_addr;
  logic [VRAM_DATA_WIDTH-1:0] vram_data;
  logic [PAL_ADDR_WIDTH-1:0]  pal_addr;
  logic [PAL_DATA_WIDTH-1:0]  pal_data;
  logic                       scan_en;
  logic [BUF_X_BITS-1:0]      scan_x;
  logic                       scan_half;
  logic [RGB_WIDTH-1:0]       rgb;
  logic                       rgb_valid;

  logic [LINE_Y_WIDTH-1:0] rec_line [MAX_REC];
  render_cfg_t             rec_cfg [MAX_REC];
  logic [RGB_WIDTH-1:0]    rec_rgb [MAX_REC][LINE_WIDTH];
  int                      num_rec;
  int                      cur_rec;
  int                      errors;
  int                      checks;
  int                      seed;
  bit                      loaded;

  tile_renderer dut_i (
    .clk       (clk),
    .reset     (reset),
    .cfg       (cfg),
    .req       (req),
    .line_y    (line_y),
    .ack       (ack),
    .map_addr  (map_addr),
    .map_data  (map_data),
    .vram_addr (vram_addr),
    .vram_data (vram_data),
    .pal_addr  (pal_addr),
    .pal_data  (pal_data),
    .scan_en   (scan_en),
    .scan_x    (scan_x),
    .scan_half (scan_half),
    .rgb       (rgb),
    .rgb_valid (rgb_valid)
  );

  tb_video_mem mem_i (
    .clk       (clk),
    .map_addr  (map_addr),
    .map_data  (map_data),
    .vram_addr (vram_addr),
    .vram_data (vram_data),
    .pal_addr  (pal_addr),
    .pal_data  (pal_data)
  );

  always #50 clk = ~clk;

  task automatic check_rgb(input logic [RGB_WIDTH-1:0] got, input logic [RGB_WIDTH-1:0] exp,
                           input int rec, input int x);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error rgb record %0d x %0d: got %05h expected %05h", rec, x, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error %s: got %0h expected %0h", name, got, exp);
    end
  endtask

  // Next hex token, skipping comment lines
  task automatic read_token(input int fd, output logic [31:0] val, output bit ok);
    string tok;
    string rest;
    int    n;
    val = '0;
    n = $fscanf(fd, "%s", tok);
    while (n == 1 && tok.substr(0, 1) == "//") begin
      n = $fgets(rest, fd);
      n = $fscanf(fd, "%s", tok);
    end
    ok = (n == 1);
    if (ok) begin
      n = $sscanf(tok, "%h", val);
    end
  endtask

  task automatic load_golden();
    int          fd;
    logic [31:0] v;
    logic [31:0] fld [FIELDS];
    bit          ok;
    layer_cfg_t  lc;
    num_rec = 0;
    fd = $fopen("test/tile_render_golden.hex", "r");
    if (fd != 0) begin
      read_token(fd, v, ok);
      while (ok && num_rec < MAX_REC) begin
        rec_line[num_rec] = v[LINE_Y_WIDTH-1:0];
        read_token(fd, v, ok);
        rec_cfg[num_rec].scroll_x = v[X_WIDTH-1:0];
        read_token(fd, v, ok);
        rec_cfg[num_rec].scroll_y = v[LINE_Y_WIDTH-1:0];
        for (int l = 0; l < NUM_LAYERS; l++) begin
          for (int f = 0; f < FIELDS; f++) begin
            read_token(fd, v, ok);
            fld[f] = v;
          end
          lc.enabled       = fld[0][0];
          lc.enable_flip   = fld[1][0];
          lc.enable_nop    = fld[2][0];
          lc.enable_transp = fld[3][0];
          lc.pal_bank      = fld[4][PAL_BANK_WIDTH-1:0];
          lc.nop_value     = fld[5][MAP_DATA_WIDTH-1:0];
          lc.color_key     = fld[6][TEXEL_WIDTH-1:0];
          lc.data_offset   = fld[7][VRAM_ADDR_WIDTH-1:0];
          lc.offset_x      = fld[8][X_WIDTH-1:0];
          lc.offset_y      = fld[9][LINE_Y_WIDTH-1:0];
          rec_cfg[num_rec].layer[LAYER_BITS'(l)] = lc;
        end
        for (int x = 0; x < LINE_WIDTH; x++) begin
          read_token(fd, v, ok);
          rec_rgb[num_rec][x] = v[RGB_WIDTH-1:0];
        end
        if (ok) begin
          num_rec++;
        end
        read_token(fd, v, ok);
      end
      $fclose(fd);
    end
  endtask

  // Scans one half and compares each pixel two cycles after its address
  task automatic scan_line(input logic half, input int rec, input bit shuffle);
    int order [LINE_WIDTH];
    int start;
    start = shuffle ? int'($unsigned($random(seed)) % LINE_WIDTH) : 0;
    for (int i = 0; i < LINE_WIDTH; i++) begin
      order[i] = (start + i) % LINE_WIDTH;
    end
    for (int i = 0; i <= LINE_WIDTH + 2; i++) begin
      @(negedge clk);
      if (i >= 2 && i < LINE_WIDTH + 2) begin
        check_flag("rgb_valid", rgb_valid, 1'b1);
        check_rgb(rgb, rec_rgb[rec][order[i-2]], rec, order[i-2]);
      end else if (i == LINE_WIDTH + 2) begin
        check_flag("rgb_valid", rgb_valid, 1'b0);
        check_rgb(rgb, '0, rec, -1);
      end
      if (i < LINE_WIDTH) begin
        scan_en   = 1'b1;
        scan_x    = BUF_X_BITS'(order[i]);
        scan_half = half;
      end else begin
        scan_en = 1'b0;
      end
    end
  endtask

  task automatic render_line(input int rec);
    int layers;
    int cycles;
    int expect_cycles;
    layers = int'(rec_cfg[rec].layer[0].enabled) + int'(rec_cfg[rec].layer[1].enabled);
    expect_cycles = 1 + LINE_WIDTH * layers + PIPE_DEPTH;
    @(negedge clk);
    check_flag("ack", ack, 1'b0);
    cfg    = rec_cfg[rec];
    line_y = rec_line[rec];
    req    = 1'b1;
    cycles = 0;
    while (!ack && cycles < 1 + LINE_WIDTH * NUM_LAYERS + PIPE_DEPTH + 16) begin
      @(negedge clk);
      cycles++;
    end
    if (!ack) begin
      errors++;
      $display("Record %0d: the DUT never raised ack", rec);
    end else begin
      if (cycles != expect_cycles) begin
        errors++;
        $display("Record %0d: ack came after %0d cycles instead of %0d", rec, cycles,
                 expect_cycles);
      end
      // Ack holds for as long as the request does
      @(negedge clk);
      check_flag("ack", ack, 1'b1);
    end
    req = 1'b0;
    @(negedge clk);
    check_flag("ack", ack, 1'b0);
  endtask

  // Scan with scan_en low gives blank output
  task automatic check_idle_outputs();
    check_flag("ack", ack, 1'b0);
    check_flag("rgb_valid", rgb_valid, 1'b0);
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      scan_en = 1'b0;
      scan_x  = BUF_X_BITS'(i);
      check_rgb(rgb, '0, -1, i);
      check_flag("rgb_valid", rgb_valid, 1'b0);
    end
  endtask

  initial begin
    longint limit_ns;
    wait (loaded);
    limit_ns = (longint'(num_rec) * (1 + 128 + 3 + 70) + 16) * 100 * 2;
    #(limit_ns);
    $display("Timeout after %0d ns while record %0d was running", limit_ns, cur_rec);
    $display("Test failed");
    $finish;
  end

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    cfg       = '0;
    req       = 1'b0;
    line_y    = '0;
    scan_en   = 1'b0;
    scan_x    = '0;
    scan_half = 1'b0;
    errors    = 0;
    checks    = 0;
    cur_rec   = -1;
    seed      = 95;
    load_golden();
    loaded = 1'b1;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    if (num_rec == 0) begin
      errors++;
      $display("Golden file is missing or holds no complete record");
    end else begin
      check_idle_outputs();
      for (int r = 0; r < num_rec; r++) begin
        cur_rec = r;
        // Other half keeps the previous line while this one draws
        fork
          render_line(r);
          if (r > 0 && rec_line[r-1][0] != rec_line[r][0]) begin
            scan_line(rec_line[r-1][0], r - 1, 1'b0);
          end
        join
        scan_line(rec_line[r][0], r, 1'b1);
      end
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: sources.f
src/tile_render_pkg.sv
src/render_sequencer.sv
src/tile_map_stage.sv
src/texel_fetch_stage.sv
src/palette_stage.sv
src/line_buffer.sv
src/tile_renderer.sv
test/tb_video_mem.sv
test/tile_renderer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the tile renderer testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module tile_renderer_tb \
  -Mdir obj_dir -o tile_renderer_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tile_renderer_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: test/tile_render_golden.hex
// Record: line_y scroll_x scroll_y, then per layer: enabled flip nop transp bank
// nop_value color_key data_offset offset_x offset_y, then 64 expected rgb words
00 00 00  1 0 0 0 0 00 00 0000 00 00  0 0 0 0 0 00 00 0000 00 00
009d8 00627 009d8 00627 009d8 00627 009d8 00627 00fc0 0003f 00fc0 0003f 00fc0 0003f 00fc0 0003f
005e8 00a17 005e8 00a17 005e8 00a17 005e8 00a17 00bd0 0042f 00bd0 0042f 00bd0 0042f 00bd0 0042f
001f8 00e07 001f8 00e07 001f8 00e07 001f8 00e07 007e0 0081f 007e0 0081f 007e0 0081f 007e0 0081f
00dc8 00237 00dc8 00237 00dc8 00237 00dc8 00237 003f0 00c0f 003f0 00c0f 003f0 00c0f 003f0 00c0f
01 70 05  1 0 0 0 1 00 00 0000 03 7c  0 0 0 0 0 00 00 0000 00 00
1089d 10762 1089d 10d4a 102b5 10d4a 102b5 10d4a 102b5 10d4a 102b5 10372 10c8d 10372 10c8d 10372
10c8d 10372 10c8d 1095a 106a5 1095a 106a5 1095a 106a5 1095a 106a5 10f42 100bd 10f42 100bd 10f42
100bd 10f42 100bd 1056a 10a95 1056a 10a95 1056a 10a95 1056a 10a95 10b52 104ad 10b52 104ad 10b52
104ad 10b52 104ad 1017a 10e85 1017a 10e85 1017a 10e85 1017a 10e85 10762 1089d 10762 1089d 10762
02 00 00  1 1 0 0 2 00 00 0000 00 00  0 0 0 0 0 00 00 0000 00 00
2095a 206a5 2095a 206a5 2095a 206a5 2095a 206a5 20fc0 20f81 20f42 20f03 20ec4 20e85 20e46 20e07
204ad 20b52 204ad 20b52 204ad 20b52 204ad 20b52 2042f 2046e 204ad 204ec 2052b 2056a 205a9 205e8
20e85 2017a 20e85 2017a 20e85 2017a 20e85 2017a 2095a 206a5 2095a 206a5 2095a 206a5 2095a 206a5
203f0 203b1 20372 20333 202f4 202b5 20276 20237 20372 20c8d 20372 20c8d 20372 20c8d 20372 20c8d
03 00 00  1 0 0 0 0 00 00 0000 00 00  1 0 1 1 3 55 6d 0000 00 00
3091b 306e4 0091b 306e4 3091b 306e4 3091b 306e4 30f03 300fc 30f03 300fc 30f03 300fc 30f03 300fc
0052b 00ad4 0052b 00ad4 0052b 00ad4 0052b 00ad4 30b13 304ec 30b13 304ec 30b13 304ec 30b13 304ec
3013b 30ec4 3013b 30ec4 3013b 30ec4 3013b 30ec4 30723 308dc 30723 308dc 30723 308dc 30723 308dc
30d0b 302f4 30d0b 302f4 30d0b 302f4 30d0b 302f4 30333 30ccc 30333 30ccc 30333 30ccc 30333 30ccc
04 00 00  1 0 0 0 0 00 00 0000 00 00  0 0 1 1 3 55 6d 0000 00 00
008dc 00723 008dc 00723 008dc 00723 008dc 00723 00ec4 0013b 00ec4 0013b 00ec4 0013b 00ec4 0013b
004ec 00b13 004ec 00b13 004ec 00b13 004ec 00b13 00ad4 0052b 00ad4 0052b 00ad4 0052b 00ad4 0052b
000fc 00f03 000fc 00f03 000fc 00f03 000fc 00f03 006e4 0091b 006e4 0091b 006e4 0091b 006e4 0091b
00ccc 00333 00ccc 00333 00ccc 00333 00ccc 00333 002f4 00d0b 002f4 00d0b 002f4 00d0b 002f4 00d0b
